/* all.f */
+incdir+design
design/rv_pkg.sv
design/mem_bus_if.sv
design/alu.sv
design/register_file.sv
design/control_unit.sv
design/core.sv
design/system_memory.sv
design/rv_system.sv
sim/tb_rv_system.sv

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_e operation,
    input  wire rv_pkg::word_t   operand_a,
    input  wire rv_pkg::word_t   operand_b,
    output rv_pkg::word_t        result,
    output logic                 zero
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];     // rv32i only looks at five bits

    always_comb begin
        case (operation)
            ADD:     result = operand_a + operand_b;
            SUB:     result = operand_a - operand_b;
            SLL:     result = operand_a << shamt;
            SLT:     result = word_t'($signed(operand_a) < $signed(operand_b));
            SLTU:    result = word_t'(operand_a < operand_b);
            XOR:     result = operand_a ^ operand_b;
            SRL:     result = operand_a >> shamt;
            SRA:     result = word_t'($signed(operand_a) >>> shamt);
            OR:      result = operand_a | operand_b;
            AND:     result = operand_a & operand_b;
            PASS_B:  result = operand_b;
            default: result = '0;
        endcase
    end

    // branches compare with SUB and test this flag
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* design/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            halt,
    input  wire rv_pkg::opcode_e opcode,
    input  wire logic [2:0]      funct3,
    input  wire logic [6:0]      funct7,
    input  wire logic            response,
    output logic                 mem_read,
    output logic                 mem_write,
    output rv_pkg::ctrl_t        ctrl,
    output rv_pkg::alu_op_e      alu_operation,
    output logic                 stopped
);
    import rv_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    logic        resp_pending;     // response that arrived while halted
    logic        resp_seen;

    assign resp_seen = response | resp_pending;
    assign stopped   = (state == STOPPED);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= RESET_WAIT;
            resp_pending <= 1'b0;
        end else begin
            state        <= next_state;
            resp_pending <= halt & (resp_pending | response);
        end
    end

    // ============================================================
    // funct decode, used when ctrl.alu_func is set
    // ============================================================
    always_comb begin
        case (opcode)
            OP, OP_IMM: begin
                case (funct3)
                    3'b000:  alu_operation = (opcode == OP && funct7[5]) ? SUB : ADD;
                    3'b001:  alu_operation = SLL;
                    3'b010:  alu_operation = SLT;
                    3'b011:  alu_operation = SLTU;
                    3'b100:  alu_operation = XOR;
                    3'b101:  alu_operation = funct7[5] ? SRA : SRL;
                    3'b110:  alu_operation = OR;
                    default: alu_operation = AND;
                endcase
            end
            BRANCH:  alu_operation = SUB;
            LUI:     alu_operation = PASS_B;
            default: alu_operation = ADD;
        endcase
    end

    // ============================================================
    // state sequencing and strobes
    // ============================================================
    always_comb begin
        ctrl       = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        next_state = state;
        case (state)
            RESET_WAIT: next_state = FETCH;
            FETCH: begin
                mem_read       = 1'b1;
                ctrl.alu_src_b = SRC_B_FOUR;            // pc + 4 written with the ir
                if (resp_seen) begin
                    ctrl.ir_write = 1'b1;
                    ctrl.pc_write = 1'b1;
                    next_state    = DECODE;
                end
            end
            DECODE: begin
                // jal keeps its link here, everything else the branch target
                ctrl.alu_src_a = SRC_A_OLD_PC;
                ctrl.alu_src_b = (opcode == JAL) ? SRC_B_FOUR : SRC_B_IMM;
                case (opcode)
                    OP, OP_IMM, LUI, LOAD, STORE, BRANCH, JAL: next_state = EXECUTE;
                    default: next_state = STOPPED;      // ebreak or an unknown opcode
                endcase
            end
            EXECUTE: begin
                ctrl.alu_src_a = SRC_A_RS1;
                ctrl.alu_src_b = SRC_B_IMM;
                ctrl.alu_func  = (opcode != LOAD && opcode != STORE && opcode != JAL);
                case (opcode)
                    OP: begin
                        ctrl.alu_src_b = SRC_B_RS2;
                        next_state     = WRITEBACK;
                    end
                    LUI: begin
                        ctrl.alu_src_a = SRC_A_ZERO;
                        next_state     = WRITEBACK;
                    end
                    LOAD, STORE: next_state = MEM_ACCESS;
                    BRANCH: begin
                        ctrl.alu_src_b     = SRC_B_RS2;
                        ctrl.pc_write_cond = 1'b1;
                        ctrl.branch_ne     = funct3[0];
                        next_state         = FETCH;
                    end
                    JAL: begin
                        ctrl.alu_src_a = SRC_A_OLD_PC;
                        ctrl.pc_write  = 1'b1;
                        ctrl.reg_write = 1'b1;
                        next_state     = FETCH;
                    end
                    default: next_state = WRITEBACK;    // op_imm
                endcase
            end
            MEM_ACCESS: begin
                ctrl.alu_src_a = SRC_A_RS1;             // hold the address in the alu output
                ctrl.alu_src_b = SRC_B_IMM;
                ctrl.addr_sel  = 1'b1;
                mem_read       = (opcode == LOAD);
                mem_write      = (opcode == STORE);
                if (resp_seen) begin
                    next_state = (opcode == LOAD) ? WRITEBACK : FETCH;
                end
            end
            WRITEBACK: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = (opcode == LOAD);
                next_state     = FETCH;
            end
            default: next_state = STOPPED;
        endcase
        if (halt) begin
            next_state         = state;
            ctrl.ir_write      = 1'b0;
            ctrl.pc_write      = 1'b0;
            ctrl.pc_write_cond = 1'b0;
            ctrl.reg_write     = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module core (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic halt,
    mem_bus_if.core   bus,
    output logic      done
);
    import rv_pkg::*;

    ctrl_t   ctrl;
    alu_op_e alu_operation;
    alu_op_e alu_sel;
    opcode_e opcode;
    logic    alu_zero;
    logic    branch_taken;
    word_t   pc, pc_old, ir, mdr, a_q, b_q, alu_out_q;
    word_t   rs1_data, rs2_data, wb_data, imm;
    word_t   alu_a, alu_b, alu_result, pc_next;

    assign opcode = opcode_e'(ir[6:0]);

    control_unit u_control (
        .clk, .reset, .halt, .opcode,
        .funct3        (ir[14:12]),
        .funct7        (ir[31:25]),
        .response      (bus.response),
        .mem_read      (bus.read),
        .mem_write     (bus.write),
        .ctrl,
        .alu_operation,
        .stopped       (done)
    );

    // ============================================================
    // immediates and operand selection
    // ============================================================
    always_comb begin
        case (opcode)
            STORE:   imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            BRANCH:  imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            LUI:     imm = {ir[31:12], 12'b0};
            JAL:     imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default: imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_a)
            SRC_A_PC:     alu_a = pc;
            SRC_A_RS1:    alu_a = a_q;
            SRC_A_OLD_PC: alu_a = pc_old;       // address of the instruction in ir
            default:      alu_a = '0;
        endcase
        case (ctrl.alu_src_b)
            SRC_B_RS2:  alu_b = b_q;
            SRC_B_FOUR: alu_b = word_t'(4);
            default:    alu_b = imm;
        endcase
    end

    assign alu_sel = ctrl.alu_func ? alu_operation : ADD;

    alu u_alu (
        .operation (alu_sel),
        .operand_a (alu_a),
        .operand_b (alu_b),
        .result    (alu_result),
        .zero      (alu_zero)
    );

    assign wb_data = ctrl.wb_sel ? mdr : alu_out_q;

    register_file u_regs (
        .clk, .reset,
        .write_en    (ctrl.reg_write),
        .read_idx_1  (ir[19:15]),
        .read_idx_2  (ir[24:20]),
        .write_idx   (ir[11:7]),
        .write_data  (wb_data),
        .read_data_1 (rs1_data),
        .read_data_2 (rs2_data)
    );

    // ============================================================
    // pc and datapath registers
    // ============================================================
    assign branch_taken = ctrl.pc_write_cond & (alu_zero ^ ctrl.branch_ne);
    assign pc_next      = ctrl.pc_write_cond ? alu_out_q : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_BOOT_ADDR;
        end else if (ctrl.pc_write || branch_taken) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!halt) begin
            a_q       <= rs1_data;
            b_q       <= rs2_data;
            alu_out_q <= alu_result;
        end
        if (bus.response) mdr <= bus.read_data;    // also caught while halted
        if (ctrl.ir_write) begin
            ir     <= bus.response ? bus.read_data : mdr;
            pc_old <= pc;
        end
    end

    assign bus.address    = ctrl.addr_sel ? alu_out_q : pc;
    assign bus.write_data = b_q;

endmodule

`default_nettype wire

/* design/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// word bus between the core and its memory, requests are levels held until response
interface mem_bus_if;
    import rv_pkg::*;

    logic  read;
    logic  write;
    word_t address;
    word_t write_data;
    word_t read_data;
    logic  response;        // one-cycle pulse, read_data valid in the same cycle

    modport core (output read, write, address, write_data, input read_data, response);
    modport memory (input read, write, address, write_data, output read_data, response);

endinterface

`default_nettype wire

/* design/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             write_en,
    input  wire rv_pkg::reg_idx_t read_idx_1,
    input  wire rv_pkg::reg_idx_t read_idx_2,
    input  wire rv_pkg::reg_idx_t write_idx,
    input  wire rv_pkg::word_t    write_data,
    output rv_pkg::word_t         read_data_1,
    output rv_pkg::word_t         read_data_2
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;     // x0 never leaves zero
        end
    end

    assign read_data_1 = regs[read_idx_1];
    assign read_data_2 = regs[read_idx_2];

endmodule

`default_nettype wire

/* design/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width of the core
`define RV_XLEN       32
// first instruction fetched after reset
`define RV_BOOT_ADDR  32'h0000_0000
`define RV_MEM_WORDS  256
// cycles from a request edge to its response pulse
`define RV_MEM_WAIT   2

`endif

/* design/rv_pkg.sv */
`default_nettype none
`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        RESET_WAIT, FETCH, DECODE, EXECUTE, MEM_ACCESS, WRITEBACK, STOPPED
    } ctrl_state_e;

    typedef enum logic [1:0] {SRC_A_PC, SRC_A_RS1, SRC_A_ZERO, SRC_A_OLD_PC} src_a_e;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_FOUR, SRC_B_IMM} src_b_e;

    typedef struct packed {
        logic   ir_write;
        logic   pc_write;
        logic   pc_write_cond;
        logic   branch_ne;      // branch taken on a nonzero compare
        logic   addr_sel;       // 0 pc, 1 alu output register
        src_a_e alu_src_a;
        src_b_e alu_src_b;
        logic   alu_func;       // 1 takes the funct decode, 0 forces add
        logic   reg_write;
        logic   wb_sel;         // 0 alu output register, 1 memory data register
    } ctrl_t;

endpackage

`default_nettype wire

/* design/rv_system.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_system (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          halt,
    input  wire logic          load_en,
    input  wire rv_pkg::word_t load_addr,
    input  wire rv_pkg::word_t load_data,
    input  wire rv_pkg::word_t peek_addr,
    output rv_pkg::word_t      peek_data,
    output logic               done
);

    mem_bus_if bus ();

    core u_core (
        .clk,
        .reset,
        .halt,
        .bus  (bus.core),
        .done
    );

    // loader and peek ports bypass the bus timing
    system_memory u_memory (
        .clk,
        .reset,
        .bus       (bus.memory),
        .load_en,
        .load_addr,
        .load_data,
        .peek_addr,
        .peek_data
    );

endmodule

`default_nettype wire

/* design/system_memory.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module system_memory (
    input  wire logic          clk,
    input  wire logic          reset,
    mem_bus_if.memory          bus,
    input  wire logic          load_en,
    input  wire rv_pkg::word_t load_addr,
    input  wire rv_pkg::word_t load_data,
    input  wire rv_pkg::word_t peek_addr,
    output rv_pkg::word_t      peek_data
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(`RV_MEM_WORDS);
    localparam int CNT_W = $clog2(`RV_MEM_WAIT + 1);

    word_t            mem [`RV_MEM_WORDS];
    logic             read_q, write_q;
    logic [CNT_W-1:0] wait_cnt;
    logic             start, fire;
    logic [IDX_W-1:0] bus_idx, load_idx, peek_idx;

    // byte addresses, the low two bits are ignored
    assign bus_idx  = bus.address[IDX_W+1:2];
    assign load_idx = load_addr[IDX_W+1:2];
    assign peek_idx = peek_addr[IDX_W+1:2];

    assign start = (bus.read & ~read_q) | (bus.write & ~write_q);
    assign fire  = (wait_cnt == CNT_W'(1)) | (start & (`RV_MEM_WAIT == 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            read_q       <= 1'b0;
            write_q      <= 1'b0;
            wait_cnt     <= '0;
            bus.response <= 1'b0;
        end else begin
            read_q       <= bus.read;
            write_q      <= bus.write;
            bus.response <= fire;
            if (start) wait_cnt <= CNT_W'(`RV_MEM_WAIT - 1);
            else if (wait_cnt != '0) wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) bus.read_data <= mem[bus_idx];
        if (load_en) begin
            mem[load_idx] <= load_data;         // loader wins over the core
        end else if (fire && bus.write) begin
            mem[bus_idx] <= bus.write_data;
        end
    end

    assign peek_data = mem[peek_idx];

endmodule

`default_nettype wire

/* sim/tb_rv_system.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module tb_rv_system;
    import rv_pkg::*;

    localparam word_t       EBREAK   = 32'h0010_0073;
    localparam int          MAX_WAIT = 5000;
    // funct3 and funct7 bit 5 of add, sub, xor, or, and, slt, sltu, sll, srl, sra
    localparam logic [29:0] OP_F3  = {3'd5, 3'd5, 3'd1, 3'd3, 3'd2, 3'd7, 3'd6, 3'd4, 3'd0, 3'd0};
    localparam logic [9:0]  OP_ALT = 10'b10_0000_0010;

    logic  clk = 1'b0;
    logic  reset, halt, load_en, done;
    word_t load_addr, load_data, peek_addr, peek_data;
    word_t prog [$];
    word_t data_addr [$];
    word_t data_val [$];

    always #5 clk = ~clk;

    rv_system dut (
        .clk, .reset, .halt, .load_en, .load_addr, .load_data,
        .peek_addr, .peek_data, .done
    );

    // ============================================================
    // instruction encoding straight from the RV32I formats
    // ============================================================
    function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t lw(reg_idx_t rd, reg_idx_t rs1, logic [11:0] off);
        return {off, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t sw(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t jal(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // expected result of an OP instruction by funct3 and the alternate bit
    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t fill_word(logic [7:0] idx);
        return {8'hd1, idx, ~idx, idx ^ 8'h5a};
    endfunction

    // ============================================================
    // checks and bus helpers
    // ============================================================
    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_done(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic load_word(word_t addr, word_t data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    task automatic expect_word(string name, word_t addr, word_t exp);
        @(posedge clk);
        peek_addr <= addr;
        @(negedge clk);             // peek is combinational and has settled by now
        check_word(name, peek_data, exp);
    endtask

    task automatic begin_test();
        prog.delete();
        data_addr.delete();
        data_val.delete();
    endtask

    // memory is refilled every test so stale results cannot pass
    task automatic start_program();
        @(posedge clk);
        reset <= 1'b1;
        halt  <= 1'b0;
        for (int i = 0; i < `RV_MEM_WORDS; i++) begin
            load_word(word_t'(i * 4), fill_word(i[7:0]));
        end
        foreach (prog[i]) load_word(word_t'(i * 4), prog[i]);
        foreach (data_val[i]) load_word(data_addr[i], data_val[i]);
        @(posedge clk);
        load_en <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_done("done after reset", done, 1'b0);
    endtask

    task automatic wait_done(string what);
        int n;
        n = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > MAX_WAIT) begin
                report_failure($sformatf("timeout: done never rose in the %s test", what));
            end
        end
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic alu_test();
        logic [11:0] ia, ib;
        word_t       a, b;
        begin_test();
        ia = 12'($urandom);
        ib = 12'($urandom);
        a  = {{20{ia[11]}}, ia};
        b  = {{20{ib[11]}}, ib};
        prog.push_back(addi(1, 0, ia));
        prog.push_back(addi(2, 0, ib));
        for (int k = 0; k < 10; k++) begin
            prog.push_back(r_type({1'b0, OP_ALT[k], 5'b0}, 2, 1, OP_F3[k*3 +: 3], 3));
            prog.push_back(sw(3, 0, 12'(32'h200 + k * 4)));
        end
        prog.push_back(EBREAK);
        start_program();
        wait_done("alu");
        for (int k = 0; k < 10; k++) begin
            expect_word($sformatf("alu result %0d", k), word_t'(32'h200 + k * 4),
                        alu_model(OP_F3[k*3 +: 3], OP_ALT[k], a, b));
        end
    endtask

    task automatic mem_test();
        word_t       d;
        logic [19:0] up;
        begin_test();
        d  = $urandom;
        up = 20'($urandom);
        data_addr.push_back(32'h300);
        data_val.push_back(d);
        prog.push_back(lw(5, 0, 12'h300));
        prog.push_back(lui(6, up));
        prog.push_back(r_type(7'h00, 6, 5, 3'd0, 7));      // x7 = x5 + x6
        prog.push_back(sw(7, 0, 12'h304));
        prog.push_back(sw(6, 0, 12'h308));
        prog.push_back(lw(8, 0, 12'h304));
        prog.push_back(r_type(7'h20, 5, 8, 3'd0, 9));      // x9 = x8 - x5
        prog.push_back(sw(9, 0, 12'h30c));
        prog.push_back(EBREAK);
        start_program();
        wait_done("load and store");
        expect_word("loaded sum", 32'h304, d + {up, 12'h000});
        expect_word("lui value", 32'h308, {up, 12'h000});
        expect_word("reloaded difference", 32'h30c, {up, 12'h000});
    endtask

    // sums 1..n into x2, stores it, then beq jumps over a store of zero
    task automatic build_sum_program(logic [11:0] n);
        prog.push_back(addi(1, 0, n));
        prog.push_back(addi(2, 0, 12'd0));
        prog.push_back(addi(3, 0, 12'd0));
        prog.push_back(addi(3, 3, 12'd1));
        prog.push_back(r_type(7'h00, 3, 2, 3'd0, 2));
        prog.push_back(branch(3'b001, 3, 1, -13'd8));
        prog.push_back(sw(2, 0, 12'h200));
        prog.push_back(branch(3'b000, 3, 1, 13'd8));
        prog.push_back(sw(0, 0, 12'h204));                  // poison
        prog.push_back(EBREAK);
    endtask

    task automatic branch_test();
        int n;
        begin_test();
        n = 5 + ($urandom % 11);
        build_sum_program(12'(n));
        start_program();
        wait_done("branch");
        expect_word("loop sum", 32'h200, word_t'(n * (n + 1) / 2));
        expect_word("poison word", 32'h204, fill_word(8'd129));
    endtask

    task automatic jal_test();
        begin_test();
        prog.push_back(addi(5, 0, 12'd7));
        prog.push_back(jal(1, 21'd8));                      // from 4 over the store at 8
        prog.push_back(sw(5, 0, 12'h200));
        prog.push_back(sw(1, 0, 12'h204));
        prog.push_back(EBREAK);
        start_program();
        wait_done("jal");
        expect_word("skipped store", 32'h200, fill_word(8'd128));
        expect_word("link register", 32'h204, 32'd8);
    endtask

    task automatic halt_test();
        int delay;
        begin_test();
        build_sum_program(12'd20);
        start_program();
        delay = 20 + ($urandom % 40);
        repeat (delay) @(posedge clk);
        halt <= 1'b1;
        // outlasts the whole program, so a core that ran on would raise done here
        repeat (500) begin
            @(negedge clk);
            check_done("done while halted", done, 1'b0);
        end
        @(posedge clk);
        halt <= 1'b0;
        wait_done("halt");
        expect_word("sum after halt", 32'h200, 32'd210);
        expect_word("poison after halt", 32'h204, fill_word(8'd129));
    endtask

    task automatic zero_reg_test();
        begin_test();
        data_addr.push_back(32'h300);
        data_val.push_back($urandom | 32'h1);               // never zero
        prog.push_back(addi(1, 0, 12'd5));
        prog.push_back(addi(0, 0, 12'd123));
        prog.push_back(lui(0, 20'habcde));
        prog.push_back(r_type(7'h00, 1, 1, 3'd0, 0));
        prog.push_back(lw(0, 0, 12'h300));
        prog.push_back(sw(0, 0, 12'h200));
        prog.push_back(sw(1, 0, 12'h204));
        prog.push_back(EBREAK);
        start_program();
        wait_done("register 0");
        expect_word("stored x0", 32'h200, 32'd0);
        expect_word("stored x1", 32'h204, 32'd5);
    endtask

    initial begin
        void'($urandom(32'hc5b));
        reset     = 1'b1;
        halt      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        peek_addr = '0;
        repeat (4) @(posedge clk);
        alu_test();
        alu_test();
        mem_test();
        branch_test();
        jal_test();
        halt_test();
        zero_reg_test();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
